/* cursor_overlay.f */
src/cursor_pkg.sv
src/video_timing.sv
src/cursor_shape.sv
src/cursor_sprite.sv
src/pixel_mixer.sv
src/cursor_overlay.sv
verification/tb_cursor_overlay.sv

/* run_sim.sh */
#!/bin/sh
# Build the cursor overlay testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --timescale 1ns/1ps \
  --top-module tb_cursor_overlay -Mdir obj_dir -f cursor_overlay.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_cursor_overlay > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Regression passed" "$LOG"; then
  echo "Simulation result: PASS"
  exit 0
else
  echo "Simulation result: FAIL"
  exit 1
fi

/* src/cursor_overlay.sv */
// Top level of the cursor overlay joining raster timing, parallel sprite engines and the pixel mixer
`timescale 1ns/1ps

module cursor_overlay import cursor_pkg::*; #(
  parameter int N_CURSORS = 2,
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33
) (
  input  logic                       clk,
  input  logic                       rst_n,
  // One strobe and one slice per cursor
  input  logic [N_CURSORS-1:0]       pos_load,
  input  logic [N_CURSORS*X_W-1:0]   cursor_x,
  input  logic [N_CURSORS*Y_W-1:0]   cursor_y,
  input  logic [N_CURSORS*RGB_W-1:0] cursor_rgb,
  input  logic [RGB_W-1:0]           bg_rgb,
  output logic                       hsync_n,
  output logic                       vsync_n,
  output logic                       de,
  output logic [RGB_W-1:0]           rgb
);

  // Stage 0 timing
  logic [X_W-1:0]             hcount;
  logic [Y_W-1:0]             vcount;
  logic                       de_t;
  logic                       hsync_t;
  logic                       vsync_t;
  logic                       frame_start;
  // Stage 1 sprite results
  logic [N_CURSORS-1:0]       hit;
  logic [N_CURSORS*RGB_W-1:0] hit_rgb;

  video_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) u_timing (
    .clk         (clk),
    .rst_n       (rst_n),
    .hcount      (hcount),
    .vcount      (vcount),
    .de_t        (de_t),
    .hsync_t     (hsync_t),
    .vsync_t     (vsync_t),
    .frame_start (frame_start)
  );

  // Sprite engines run side by side on the same counters
  for (genvar i = 0; i < N_CURSORS; i++) begin : g_sprite
    cursor_sprite u_sprite (
      .clk         (clk),
      .rst_n       (rst_n),
      .hcount      (hcount),
      .vcount      (vcount),
      .frame_start (frame_start),
      .pos_load    (pos_load[i]),
      .cursor_x    (cursor_x[i*X_W +: X_W]),
      .cursor_y    (cursor_y[i*Y_W +: Y_W]),
      .cursor_rgb  (cursor_rgb[i*RGB_W +: RGB_W]),
      .hit         (hit[i]),
      .hit_rgb     (hit_rgb[i*RGB_W +: RGB_W])
    );
  end

  pixel_mixer #(
    .N_CURSORS (N_CURSORS)
  ) u_mixer (
    .clk     (clk),
    .rst_n   (rst_n),
    .hit     (hit),
    .hit_rgb (hit_rgb),
    .bg_rgb  (bg_rgb),
    .de_t    (de_t),
    .hsync_t (hsync_t),
    .vsync_t (vsync_t),
    .rgb     (rgb),
    .de      (de),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n)
  );

endmodule

/* src/cursor_pkg.sv */
// Shared widths, arrow shape constants and state enums, imported by every cursor overlay module
package cursor_pkg;

  // Pixel and line counter widths, also used for cursor coordinates
  localparam int X_W = 11;
  localparam int Y_W = 10;

  // Pixel colour, 4 bits per channel
  localparam int RGB_W = 12;

  // Arrow shape row number and row bitmap widths
  localparam int LINE_NUM_W  = 5;
  localparam int LINE_CODE_W = 8;

  // Cursor is LINE_CODE_W pixels wide
  // Rows 0 to LINE_CODE_W-1 grow, rows up to CURSOR_ROWS-1 shrink
  localparam int CURSOR_ROWS = 11;

  // Bits needed to pick one pixel out of a line code
  localparam int COL_IDX_W = $clog2(LINE_CODE_W);

  // Span of a scan axis, shared by horizontal and vertical timing
  typedef enum logic [1:0] {
    ACTIVE,
    FRONT,
    SYNC,
    BACK
  } scan_phase_e;

  // Arrow row zones
  // RISING widens by one pixel per row
  // FALLING narrows toward the tail
  typedef enum logic [1:0] {
    RISING,
    FALLING,
    BLANK
  } shape_zone_e;

endpackage

/* src/cursor_shape.sv */
// Arrow cursor row lookup turning a row number into its pixel bitmap, checked by local assertions
`timescale 1ns/1ps

module cursor_shape import cursor_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [LINE_NUM_W-1:0]  line_number,
  output logic [LINE_CODE_W-1:0] line_code
);

  shape_zone_e           zone;
  logic [LINE_NUM_W-1:0] run_len;
  // One spare bit so a full row of ones survives the shift
  logic [LINE_CODE_W:0]  code_wide;

  // Row classification
  always_comb begin
    if (line_number < LINE_NUM_W'(LINE_CODE_W)) begin
      zone = RISING;
    end else if (line_number < LINE_NUM_W'(CURSOR_ROWS)) begin
      zone = FALLING;
    end else begin
      zone = BLANK;
    end
  end

  // Number of lit pixels on this row
  always_comb begin
    case (zone)
      RISING:  run_len = line_number + 1'b1;
      FALLING: run_len = LINE_NUM_W'(CURSOR_ROWS) - line_number;
      default: run_len = '0;
    endcase
  end

  // Run of ones starting at the left pixel
  assign code_wide = ((LINE_CODE_W + 1)'(1) << run_len) - 1'b1;
  assign line_code = code_wide[LINE_CODE_W-1:0];

  // Each row is a solid run from the left edge
  a_solid_run: assert property (@(posedge clk) disable iff (!rst_n)
    (line_code & LINE_CODE_W'(line_code + 1'b1)) == '0
  ) else $error("line_code 0x%0h is not a solid run", line_code);

  // Known row in gives a known bitmap out
  a_known_out: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown(line_number) |-> !$isunknown(line_code)
  ) else $error("line_code unknown for row %0d", line_number);

  // Lookup holds no state across cycles
  a_stable_out: assert property (@(posedge clk) disable iff (!rst_n)
    $stable(line_number) |-> $stable(line_code)
  ) else $error("line_code moved while row %0d held", line_number);

endmodule

/* src/cursor_sprite.sv */
// One cursor sprite engine with frame-synchronous position and colour loads and per-pixel hit test
`timescale 1ns/1ps

module cursor_sprite import cursor_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic [X_W-1:0]   hcount,
  input  logic [Y_W-1:0]   vcount,
  input  logic             frame_start,
  input  logic             pos_load,
  input  logic [X_W-1:0]   cursor_x,
  input  logic [Y_W-1:0]   cursor_y,
  input  logic [RGB_W-1:0] cursor_rgb,
  output logic             hit,
  output logic [RGB_W-1:0] hit_rgb
);

  logic [X_W-1:0]         shadow_x, live_x, eff_x;
  logic [Y_W-1:0]         shadow_y, live_y, eff_y;
  logic [RGB_W-1:0]       shadow_rgb, live_rgb, eff_rgb;
  logic                   pending;
  logic                   apply;
  logic [X_W-1:0]         col_off;
  logic [Y_W-1:0]         row_off;
  logic                   row_in, col_in;
  logic [LINE_CODE_W-1:0] line_code;

  // Shadow takes every strobe, last one before frame start wins
  always_ff @(posedge clk) begin
    if (pos_load) begin
      shadow_x   <= cursor_x;
      shadow_y   <= cursor_y;
      shadow_rgb <= cursor_rgb;
    end
  end

  // Pending load is copied to the live set at frame start
  assign apply = frame_start && pending;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending  <= 1'b0;
      // Park off screen in the far corner
      live_x   <= '1;
      live_y   <= '1;
      live_rgb <= '0;
    end else begin
      if (apply) begin
        live_x   <= shadow_x;
        live_y   <= shadow_y;
        live_rgb <= shadow_rgb;
      end
      // A strobe on the frame start edge stays pending for the next frame
      if (pos_load) begin
        pending <= 1'b1;
      end else if (apply) begin
        pending <= 1'b0;
      end
    end
  end

  // Pixel 0,0 of the new frame already sees the new position
  assign eff_x   = apply ? shadow_x : live_x;
  assign eff_y   = apply ? shadow_y : live_y;
  assign eff_rgb = apply ? shadow_rgb : live_rgb;

  // Offsets wrap to large values above and left of the cursor
  assign row_off = vcount - eff_y;
  assign col_off = hcount - eff_x;
  assign row_in  = row_off < Y_W'(CURSOR_ROWS);
  assign col_in  = col_off < X_W'(LINE_CODE_W);

  // Out of range rows give garbage codes but row_in masks them
  cursor_shape u_shape (
    .clk         (clk),
    .rst_n       (rst_n),
    .line_number (row_off[LINE_NUM_W-1:0]),
    .line_code   (line_code)
  );

  // Bit 0 of the line code is the leftmost pixel
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hit <= 1'b0;
    end else begin
      hit <= row_in && col_in && line_code[col_off[COL_IDX_W-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    hit_rgb <= eff_rgb;
  end

  // Rows below the arrow never light up
  a_no_tail_hit: assert property (@(posedge clk) disable iff (!rst_n)
    (row_off >= Y_W'(CURSOR_ROWS)) |=> !hit
  ) else $error("hit raised on row offset past the arrow");

endmodule

/* src/pixel_mixer.sv */
// Output stage choosing the highest priority cursor colour or background and aligning the syncs
`timescale 1ns/1ps

module pixel_mixer import cursor_pkg::*; #(
  parameter int N_CURSORS = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [N_CURSORS-1:0]       hit,
  input  logic [N_CURSORS*RGB_W-1:0] hit_rgb,
  input  logic [RGB_W-1:0]           bg_rgb,
  input  logic                       de_t,
  input  logic                       hsync_t,
  input  logic                       vsync_t,
  output logic [RGB_W-1:0]           rgb,
  output logic                       de,
  output logic                       hsync_n,
  output logic                       vsync_n
);

  logic [RGB_W-1:0] pick;
  // First delay stage, aligned with the sprite hits
  logic             de_d1;
  logic             hsync_d1;
  logic             vsync_d1;

  // Lowest index wins, so scan downward and let it overwrite
  always_comb begin
    pick = bg_rgb;
    for (int i = N_CURSORS - 1; i >= 0; i--) begin
      if (hit[i]) begin
        pick = hit_rgb[i*RGB_W +: RGB_W];
      end
    end
  end

  // Two-stage delay line for de and syncs
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de_d1    <= 1'b0;
      hsync_d1 <= 1'b1;
      vsync_d1 <= 1'b1;
      de       <= 1'b0;
      hsync_n  <= 1'b1;
      vsync_n  <= 1'b1;
    end else begin
      de_d1    <= de_t;
      hsync_d1 <= hsync_t;
      vsync_d1 <= vsync_t;
      de       <= de_d1;
      hsync_n  <= hsync_d1;
      vsync_n  <= vsync_d1;
    end
  end

  // Blank outside the active area
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb <= '0;
    end else if (de_d1) begin
      rgb <= pick;
    end else begin
      rgb <= '0;
    end
  end

  // Colour and enable leave through separate registers but must agree
  a_blank_rgb: assert property (@(posedge clk) disable iff (!rst_n)
    !de |-> (rgb == '0)
  ) else $error("rgb 0x%0h driven while de low", rgb);

endmodule

/* src/video_timing.sv */
// Raster timing generator producing pixel and line counters, syncs, display enable and frame start
`timescale 1ns/1ps

module video_timing import cursor_pkg::*; #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic           clk,
  input  logic           rst_n,
  output logic [X_W-1:0] hcount,
  output logic [Y_W-1:0] vcount,
  output logic           de_t,
  output logic           hsync_t,
  output logic           vsync_t,
  output logic           frame_start
);

  // Last count of each span on both axes
  localparam int H_ACT_END  = H_ACTIVE - 1;
  localparam int H_FP_END   = H_ACTIVE + H_FRONT - 1;
  localparam int H_SYNC_END = H_ACTIVE + H_FRONT + H_SYNC - 1;
  localparam int H_TOTAL    = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_ACT_END  = V_ACTIVE - 1;
  localparam int V_FP_END   = V_ACTIVE + V_FRONT - 1;
  localparam int V_SYNC_END = V_ACTIVE + V_FRONT + V_SYNC - 1;
  localparam int V_TOTAL    = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

  scan_phase_e    h_phase, h_phase_nxt;
  scan_phase_e    v_phase, v_phase_nxt;
  logic [X_W-1:0] hcount_nxt;
  logic [Y_W-1:0] vcount_nxt;
  logic           line_end;

  // Horizontal FSM steps one span per boundary count
  always_comb begin
    h_phase_nxt = h_phase;
    line_end    = 1'b0;
    hcount_nxt  = hcount + 1'b1;
    case (h_phase)
      ACTIVE: if (hcount == X_W'(H_ACT_END)) h_phase_nxt = FRONT;
      FRONT:  if (hcount == X_W'(H_FP_END)) h_phase_nxt = SYNC;
      SYNC:   if (hcount == X_W'(H_SYNC_END)) h_phase_nxt = BACK;
      BACK: begin
        if (hcount == X_W'(H_TOTAL - 1)) begin
          h_phase_nxt = ACTIVE;
          hcount_nxt  = '0;
          line_end    = 1'b1;
        end
      end
      default: h_phase_nxt = ACTIVE;
    endcase
  end

  // Vertical FSM only moves at the end of a line
  always_comb begin
    v_phase_nxt = v_phase;
    vcount_nxt  = vcount;
    if (line_end) begin
      vcount_nxt = vcount + 1'b1;
      case (v_phase)
        ACTIVE: if (vcount == Y_W'(V_ACT_END)) v_phase_nxt = FRONT;
        FRONT:  if (vcount == Y_W'(V_FP_END)) v_phase_nxt = SYNC;
        SYNC:   if (vcount == Y_W'(V_SYNC_END)) v_phase_nxt = BACK;
        BACK: begin
          if (vcount == Y_W'(V_TOTAL - 1)) begin
            v_phase_nxt = ACTIVE;
            vcount_nxt  = '0;
          end
        end
        default: v_phase_nxt = ACTIVE;
      endcase
    end
  end

  // Flags come from next-state values so they line up with the counters
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hcount      <= '0;
      vcount      <= '0;
      h_phase     <= ACTIVE;
      v_phase     <= ACTIVE;
      de_t        <= 1'b0;
      hsync_t     <= 1'b1;
      vsync_t     <= 1'b1;
      frame_start <= 1'b0;
    end else begin
      hcount      <= hcount_nxt;
      vcount      <= vcount_nxt;
      h_phase     <= h_phase_nxt;
      v_phase     <= v_phase_nxt;
      de_t        <= (h_phase_nxt == ACTIVE) && (v_phase_nxt == ACTIVE);
      // Syncs are active low
      hsync_t     <= (h_phase_nxt != SYNC);
      vsync_t     <= (v_phase_nxt != SYNC);
      frame_start <= (hcount_nxt == '0) && (vcount_nxt == '0);
    end
  end

  // Counter never runs past the line length
  a_hcount_range: assert property (@(posedge clk) disable iff (!rst_n)
    int'(hcount) < H_TOTAL
  ) else $error("hcount %0d past line total %0d", hcount, H_TOTAL);

  // Frame start is a single-cycle pulse
  a_frame_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    frame_start |=> !frame_start
  ) else $error("frame_start held for more than one cycle");

endmodule

/* verification/tb_cursor_overlay.sv */
// Self-checking testbench for the cursor overlay, run through run_sim.sh with a pixel reference model
`timescale 1ns/1ps

module tb_cursor_overlay import cursor_pkg::*; ();

  // Small raster of 44 cycles per line and 30 lines per frame
  localparam int N_CURSORS      = 2;
  localparam int H_ACTIVE       = 32;
  localparam int LINE_TOTAL     = 44;
  localparam int V_ACTIVE       = 24;
  localparam int FRAME_CYCLES   = LINE_TOTAL * 30;
  // Planned run is about six frames including the one after reset
  localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES;

  logic                       clk;
  logic                       rst_n;
  logic [N_CURSORS-1:0]       pos_load;
  logic [N_CURSORS*X_W-1:0]   cursor_x;
  logic [N_CURSORS*Y_W-1:0]   cursor_y;
  logic [N_CURSORS*RGB_W-1:0] cursor_rgb;
  logic [RGB_W-1:0]           bg_rgb;
  logic                       hsync_n;
  logic                       vsync_n;
  logic                       de;
  logic [RGB_W-1:0]           rgb;

  // Reference model shadow and live set per cursor
  logic [X_W-1:0]   sh_x [N_CURSORS];
  logic [Y_W-1:0]   sh_y [N_CURSORS];
  logic [RGB_W-1:0] sh_rgb [N_CURSORS];
  logic [X_W-1:0]   live_x [N_CURSORS];
  logic [Y_W-1:0]   live_y [N_CURSORS];
  logic [RGB_W-1:0] live_rgb [N_CURSORS];
  logic             pend [N_CURSORS];
  // Position of the pixel now on the outputs
  logic [X_W-1:0]   col_cnt;
  logic [Y_W-1:0]   row_cnt;
  logic [RGB_W-1:0] exp_rgb;
  logic             armed = 1'b0;
  logic             rst_q = 1'b0;
  logic             de_q = 1'b0;
  logic             hs_q = 1'b1;
  logic             vs_q = 1'b1;
  logic             synced = 1'b0;
  int               de_run;
  int               h_gap;
  int               v_gap;
  int               cycle_cnt;
  int               cursor_px;
  string            test_name;

  wire hs_fell = hs_q && !hsync_n;
  wire vs_fell = vs_q && !vsync_n;
  wire de_fell = de_q && !de;
  wire idle    = hsync_n && vsync_n && !de && (rgb == '0);

  cursor_overlay #(
    .N_CURSORS (N_CURSORS),
    .H_ACTIVE  (H_ACTIVE),
    .H_FRONT   (4),
    .H_SYNC    (4),
    .H_BACK    (4),
    .V_ACTIVE  (V_ACTIVE),
    .V_FRONT   (2),
    .V_SYNC    (2),
    .V_BACK    (2)
  ) u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .pos_load   (pos_load),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y),
    .cursor_rgb (cursor_rgb),
    .bg_rgb     (bg_rgb),
    .hsync_n    (hsync_n),
    .vsync_n    (vsync_n),
    .de         (de),
    .rgb        (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
    $display("Regression failed");
    $fatal(1, "check %s mismatched", name);
  endtask

  task automatic report_problem(input string what);
    $display("Error: %s", what);
    $display("Regression failed");
    $fatal(1, "%s", what);
  endtask

  // Arrow rows 0-7 are 2^(row+1)-1 wide, rows 8-10 are 2^(11-row)-1, bit 0 leftmost
  function automatic logic arrow_covers(input logic [Y_W-1:0] row, input logic [X_W-1:0] col);
    int r;
    int c;
    int width;
    r = int'(row);
    c = int'(col);
    if (r < 8) width = r + 1;
    else if (r < 11) width = 11 - r;
    else width = 0;
    return c < width;
  endfunction

  // Lowest cursor index covering the pixel wins, else background
  always_comb begin
    logic found;
    found   = 1'b0;
    exp_rgb = bg_rgb;
    for (int i = 0; i < N_CURSORS; i++) begin
      if (!found && arrow_covers(row_cnt - live_y[i], col_cnt - live_x[i])) begin
        exp_rgb = live_rgb[i];
        found   = 1'b1;
      end
    end
  end

  // Raster position and frame-boundary loads as seen at the outputs
  always @(posedge clk) begin
    armed     <= 1'b1;
    rst_q     <= rst_n;
    de_q      <= de;
    hs_q      <= hsync_n;
    vs_q      <= vsync_n;
    cycle_cnt <= cycle_cnt + 1;
    if (!rst_n) begin
      synced  <= 1'b0;
      col_cnt <= '0;
      row_cnt <= '0;
      for (int i = 0; i < N_CURSORS; i++) begin
        // Parked in the far corner with black colour
        live_x[i]   <= '1;
        live_y[i]   <= '1;
        live_rgb[i] <= '0;
        pend[i]     <= 1'b0;
      end
    end else begin
      col_cnt <= de ? col_cnt + 1'b1 : '0;
      de_run  <= de ? de_run + 1 : 0;
      h_gap   <= hs_fell ? 1 : h_gap + 1;
      v_gap   <= vs_fell ? 1 : v_gap + 1;
      // No active pixel lies between vsync fall and the next frame start
      if (vs_fell) begin
        synced  <= 1'b1;
        row_cnt <= '0;
        for (int i = 0; i < N_CURSORS; i++) begin
          if (pend[i]) begin
            live_x[i]   <= sh_x[i];
            live_y[i]   <= sh_y[i];
            live_rgb[i] <= sh_rgb[i];
            pend[i]     <= 1'b0;
          end
        end
      end else if (de_fell) begin
        row_cnt <= row_cnt + 1'b1;
      end
      // Later strobe in the same frame overwrites the shadow
      for (int i = 0; i < N_CURSORS; i++) begin
        if (pos_load[i]) begin
          sh_x[i]   <= cursor_x[i*X_W +: X_W];
          sh_y[i]   <= cursor_y[i*Y_W +: Y_W];
          sh_rgb[i] <= cursor_rgb[i*RGB_W +: RGB_W];
          pend[i]   <= 1'b1;
        end
      end
      if (synced && de && (exp_rgb != bg_rgb)) cursor_px <= cursor_px + 1;
    end
  end

  always @(posedge clk) begin
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      report_problem("run did not finish before the cycle limit");
    end
  end

  a_reset_idle: assert property (@(posedge clk) (armed && !rst_n) |-> idle)
    else report_problem("outputs were active while reset was held");

  a_release_idle: assert property (@(posedge clk) (!rst_q && rst_n) |-> idle)
    else report_problem("outputs were active on the cycle reset was released");

  // Periods only count once a full frame has been framed by vsync
  a_hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
    (synced && hs_fell) |-> (h_gap == LINE_TOTAL)
  ) else report_mismatch("hsync period", LINE_TOTAL, $sampled(h_gap));

  a_vsync_period: assert property (@(posedge clk) disable iff (!rst_n)
    (synced && vs_fell) |-> (v_gap == FRAME_CYCLES)
  ) else report_mismatch("vsync period", FRAME_CYCLES, $sampled(v_gap));

  a_de_width: assert property (@(posedge clk) disable iff (!rst_n)
    (synced && de_fell) |-> (de_run == H_ACTIVE)
  ) else report_mismatch("de width", H_ACTIVE, $sampled(de_run));

  a_frame_lines: assert property (@(posedge clk) disable iff (!rst_n)
    (synced && vs_fell) |-> (int'(row_cnt) == V_ACTIVE)
  ) else report_mismatch("lines per frame", V_ACTIVE, int'($sampled(row_cnt)));

  a_blanking: assert property (@(posedge clk) disable iff (!rst_n)
    !de |-> (rgb == '0)
  ) else report_mismatch("blanking", 0, int'($sampled(rgb)));

  a_pixel: assert property (@(posedge clk) disable iff (!rst_n)
    (synced && de) |-> (rgb == exp_rgb)
  ) else report_mismatch(test_name, int'($sampled(exp_rgb)), int'($sampled(rgb)));

  task automatic load_cursor(input int idx, input int x, input int y, input logic [RGB_W-1:0] c);
    pos_load[idx]                 <= 1'b1;
    cursor_x[idx*X_W +: X_W]      <= X_W'(x);
    cursor_y[idx*Y_W +: Y_W]      <= Y_W'(y);
    cursor_rgb[idx*RGB_W +: RGB_W] <= c;
    @(posedge clk);
    pos_load <= '0;
  endtask

  task automatic wait_next_frame();
    do @(posedge clk); while (!vs_fell);
  endtask

  task automatic wait_row(input int row);
    do @(posedge clk); while (!(de && (row_cnt == Y_W'(row))));
  endtask

  initial begin
    int               px;
    int               py;
    logic [RGB_W-1:0] c0;
    rst_n      = 1'b0;
    pos_load   = '0;
    cursor_x   = '0;
    cursor_y   = '0;
    cursor_rgb = '0;
    bg_rgb     = '0;
    test_name  = "reset";
    void'($urandom(32'h391a));
    // Colours derived from one draw so they always differ
    c0 = RGB_W'($urandom);
    @(posedge clk);
    bg_rgb <= c0 ^ 12'hf0f;
    repeat (9) @(posedge clk);
    rst_n <= 1'b1;

    // Cursor 0 fully on screen, cursor 1 parked below the active area
    test_name = "shape";
    wait_row(2);
    load_cursor(0, int'($urandom % 25), int'($urandom % 14), c0);
    load_cursor(1, 40, 26, c0 ^ 12'h0f0);
    wait_next_frame();

    // Cursor 1 offset by (2,3) so both overlap and cursor 1 shows alone
    wait_row(12);
    px = int'($urandom % 21);
    py = int'($urandom % 10);
    load_cursor(0, px, py, c0);
    load_cursor(1, px + 2, py + 3, c0 ^ 12'h0f0);
    wait_next_frame();
    test_name = "priority";

    // New rows sit below the strobe row so an early apply would show up
    wait_row(10);
    test_name = "tear_free";
    load_cursor(0, int'($urandom % 12), 12 + int'($urandom % 2), c0 ^ 12'h00f);
    repeat (3) @(posedge clk);
    load_cursor(0, 13 + int'($urandom % 12), 12 + int'($urandom % 2), c0 ^ 12'hff0);
    wait_next_frame();

    // Both cursors hang over the right and bottom edges
    wait_row(10);
    load_cursor(0, 27 + int'($urandom % 5), 16 + int'($urandom % 8), c0);
    load_cursor(1, 30, 16, c0 ^ 12'h0f0);
    wait_next_frame();
    test_name = "clipping";
    wait_next_frame();

    if (cursor_px == 0) begin
      $display("Error: no cursor pixel was ever expected on screen");
      $display("Regression failed");
      $fatal(1, "cursor stimulus never reached the pixel check");
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule
